// File: verilog/calc_pkg.sv
package calc_pkg;

	localparam int RESULT_W = 6;	// -9 .. 18 needs 6 bits signed

	typedef logic [3:0] digit_t;	// bcd digit or key code
	typedef logic signed [RESULT_W-1:0] result_t;
	typedef logic [13:0] key_bank_t;	// bit n = digit n for n < 10

	localparam digit_t DIGIT_NONE = 4'hF;	// no digit, minus on tens

	// function keys above the digits
	localparam int KEY_EQUAL = 10;
	localparam int KEY_CLEAR = 11;
	localparam int KEY_SUB   = 12;
	localparam int KEY_ADD   = 13;

	typedef struct packed {
		logic   digit_hit;	// any digit pressed this cycle
		digit_t digit;	// highest pressed digit
		logic   add;
		logic   sub;
		logic   clear;
		logic   equal;
	} key_evt_t;

	typedef enum logic [2:0] {
		IDLE,
		ENTER_A,
		ADD_WAIT_B,
		ADD_HAVE_B,
		SUB_WAIT_B,
		SUB_HAVE_B,
		ADD_DONE,
		SUB_DONE
	} calc_state_t;

	typedef struct packed {
		logic load_a;
		logic load_b;
		logic subtract;	// a - b instead of a + b
		logic show_a;
		logic show_b;
		logic show_result;
	} calc_ctrl_t;

	typedef struct packed {
		digit_t tens;	// 0, 1 or DIGIT_NONE for negative
		digit_t ones;
	} split_t;

endpackage

// File: verilog/seg_pkg.sv
package seg_pkg;

	// bit 7 = segment a ... bit 1 = segment g, bit 0 = dot
	typedef logic [7:0] seg_t;

	localparam seg_t GLYPH_0     = 8'b1111_1100;
	localparam seg_t GLYPH_1     = 8'b0110_0000;
	localparam seg_t GLYPH_2     = 8'b1101_1010;
	localparam seg_t GLYPH_3     = 8'b1111_0010;
	localparam seg_t GLYPH_4     = 8'b0110_0110;
	localparam seg_t GLYPH_5     = 8'b1011_0110;
	localparam seg_t GLYPH_6     = 8'b1011_1110;
	localparam seg_t GLYPH_7     = 8'b1110_0000;
	localparam seg_t GLYPH_8     = 8'b1111_1110;
	localparam seg_t GLYPH_9     = 8'b1111_0110;
	localparam seg_t GLYPH_MINUS = 8'b0000_0010;	// segment g only
	localparam seg_t GLYPH_ERR   = 8'b1001_1111;	// "E" with dot
	localparam seg_t GLYPH_BLANK = 8'b0000_0000;

	localparam int NUM_DIGITS = 4;

	// left to right on the bank
	typedef enum logic [1:0] {
		POS_A,
		POS_B,
		POS_TENS,
		POS_ONES
	} digit_pos_t;

	typedef logic [NUM_DIGITS-1:0] gate_t;	// one-hot, bit n = position n

endpackage

// File: verilog/key_input.sv
module key_input import calc_pkg::*; (
	input  logic      CLK,
	input  logic      RST_X,
	input  key_bank_t psw,	// active low switches
	output key_evt_t  key_evt
);

	key_bank_t sync0;	// first stage, inverted so pressed = 1
	key_bank_t sync1;	// second stage, safe to use
	key_bank_t sync2;	// delayed copy for edge detect
	key_bank_t press;	// one-cycle press pulses
	digit_t    dig;

	always_ff @(posedge CLK or negedge RST_X) begin
		if (!RST_X) begin
			sync0 <= '0;
			sync1 <= '0;
			sync2 <= '0;
		end else begin
			sync0 <= ~psw;
			sync1 <= sync0;
			sync2 <= sync1;
		end
	end

	assign press = sync1 & ~sync2;	// rising edge of pressed level

	// ascending scan, last hit wins so the highest digit takes priority
	always_comb begin
		dig = DIGIT_NONE;
		for (int i = 0; i <= 9; i++) begin
			if (press[i])
				dig = digit_t'(i);
		end
	end

	assign key_evt = '{
		digit_hit: |press[9:0],
		digit:     dig,
		add:       press[KEY_ADD],
		sub:       press[KEY_SUB],
		clear:     press[KEY_CLEAR],
		equal:     press[KEY_EQUAL]
	};

	// event names the highest pressed digit and never 4'hF
	a_digit_valid: assert property (@(posedge CLK) disable iff (!RST_X)
		key_evt.digit_hit |-> key_evt.digit <= 4'd9
			&& (press[9:0] >> key_evt.digit) == 10'd1);

endmodule

// File: verilog/calc_fsm.sv
module calc_fsm import calc_pkg::*; (
	input  logic       CLK,
	input  logic       RST_X,
	input  key_evt_t   key_evt,
	output calc_ctrl_t calc_ctrl
);

	calc_state_t state;
	calc_state_t state_nxt;

	always_ff @(posedge CLK or negedge RST_X) begin
		if (!RST_X)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	always_comb begin
		state_nxt = state;
		if (key_evt.clear) begin
			state_nxt = IDLE;	// clear beats any other key
		end else begin
			case (state)
				IDLE: begin
					if (key_evt.digit_hit)
						state_nxt = ENTER_A;
				end
				ENTER_A: begin
					if (key_evt.add)	// plus wins over minus
						state_nxt = ADD_WAIT_B;
					else if (key_evt.sub)
						state_nxt = SUB_WAIT_B;
				end
				ADD_WAIT_B: begin
					if (key_evt.digit_hit)
						state_nxt = ADD_HAVE_B;
				end
				SUB_WAIT_B: begin
					if (key_evt.digit_hit)
						state_nxt = SUB_HAVE_B;
				end
				ADD_HAVE_B: begin
					if (key_evt.equal)
						state_nxt = ADD_DONE;
				end
				SUB_HAVE_B: begin
					if (key_evt.equal)
						state_nxt = SUB_DONE;
				end
				ADD_DONE, SUB_DONE: begin
					if (key_evt.digit_hit)	// new calculation starts in a
						state_nxt = ENTER_A;
				end
				default: state_nxt = IDLE;
			endcase
		end
	end

	// control decode straight from the state register
	always_comb begin
		calc_ctrl = '0;
		case (state)
			IDLE: begin
				calc_ctrl.load_a = 1'b1;	// first digit lands in a
			end
			ENTER_A: begin
				calc_ctrl.load_a = 1'b1;	// later digits overwrite a
				calc_ctrl.show_a = 1'b1;
			end
			ADD_WAIT_B, SUB_WAIT_B: begin
				calc_ctrl.load_b = 1'b1;
				calc_ctrl.show_a = 1'b1;
			end
			ADD_HAVE_B, SUB_HAVE_B: begin
				calc_ctrl.load_b = 1'b1;
				calc_ctrl.show_a = 1'b1;
				calc_ctrl.show_b = 1'b1;
			end
			ADD_DONE, SUB_DONE: begin
				calc_ctrl.load_a      = 1'b1;
				calc_ctrl.show_a      = 1'b1;
				calc_ctrl.show_b      = 1'b1;
				calc_ctrl.show_result = 1'b1;
			end
			default: calc_ctrl = '0;
		endcase
		// minus branch keeps the subtract select
		calc_ctrl.subtract = (state == SUB_WAIT_B) || (state == SUB_HAVE_B)
			|| (state == SUB_DONE);
	end

	// every state arms exactly one operand register for the next digit
	a_one_load: assert property (@(posedge CLK) disable iff (!RST_X)
		calc_ctrl.load_a ^ calc_ctrl.load_b);

endmodule

// File: verilog/operand_result.sv
module operand_result import calc_pkg::*; (
	input  logic       CLK,
	input  logic       RST_X,
	input  key_evt_t   key_evt,
	input  calc_ctrl_t calc_ctrl,
	output digit_t     a_data,
	output digit_t     b_data,
	output split_t     split
);

	result_t a_ext;
	result_t b_ext;
	result_t result;	// signed a +/- b
	result_t mag;	// magnitude when negative
	result_t over;	// result - 10 for the ones digit
	split_t  split_nxt;

	// operand registers, load qualified by the digit pulse
	always_ff @(posedge CLK or negedge RST_X) begin
		if (!RST_X) begin
			a_data <= '0;
			b_data <= '0;
		end else if (key_evt.digit_hit) begin
			if (calc_ctrl.load_a)
				a_data <= key_evt.digit;
			if (calc_ctrl.load_b)
				b_data <= key_evt.digit;
		end
	end

	assign a_ext  = result_t'({2'b00, a_data});	// zero extend, stays positive
	assign b_ext  = result_t'({2'b00, b_data});
	assign result = calc_ctrl.subtract ? a_ext - b_ext : a_ext + b_ext;
	assign mag    = -result;
	assign over   = result - result_t'(10);

	always_comb begin
		if (result < 0) begin
			split_nxt.tens = DIGIT_NONE;	// shown as minus sign
			split_nxt.ones = mag[3:0];
		end else if (result >= 10) begin
			split_nxt.tens = 4'd1;
			split_nxt.ones = over[3:0];
		end else begin
			split_nxt.tens = 4'd0;
			split_nxt.ones = result[3:0];
		end
	end

	// one cycle behind operands, refreshed every clock
	always_ff @(posedge CLK) begin
		split <= split_nxt;
	end

	// ones digit must stay bcd for every operand pair
	a_ones_bcd: assert property (@(posedge CLK) disable iff (!RST_X)
		split.ones <= 4'd9);

endmodule

// File: verilog/scan_timer.sv
module scan_timer import seg_pkg::*; #(
	parameter int SCAN_DIV = 4	// clocks per digit position
) (
	input  logic  CLK,
	input  logic  RST_X,
	output gate_t gate
);

	localparam int CNT_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;

	logic [CNT_W-1:0] cnt;
	logic             scan_tick;	// high on the last count of a step

	assign scan_tick = (cnt == CNT_W'(SCAN_DIV - 1));

	always_ff @(posedge CLK or negedge RST_X) begin
		if (!RST_X)
			cnt <= '0;
		else if (scan_tick)
			cnt <= '0;	// wrap
		else
			cnt <= cnt + 1'b1;
	end

	// rotate toward the next position, ones wraps back to a
	always_ff @(posedge CLK or negedge RST_X) begin
		if (!RST_X)
			gate <= gate_t'(1) << POS_A;
		else if (scan_tick)
			gate <= {gate[NUM_DIGITS-2:0], gate[NUM_DIGITS-1]};
	end

	a_gate_onehot: assert property (@(posedge CLK) disable iff (!RST_X)
		$onehot(gate));

endmodule

// File: verilog/seg_display.sv
module seg_display import calc_pkg::*, seg_pkg::*; (
	input  logic       CLK,
	input  logic       RST_X,
	input  digit_t     a_data,
	input  digit_t     b_data,
	input  split_t     split,
	input  calc_ctrl_t calc_ctrl,
	input  gate_t      gate,	// one-hot from scan_timer
	output seg_t       seg_out,
	output gate_t      seg_sel	// active low digit select
);

	seg_t glyph [NUM_DIGITS];	// encoded pattern per position
	seg_t sel_glyph;

	// blank_zero suppresses a leading zero on the tens digit
	function automatic seg_t encode(digit_t d, logic ena, logic blank_zero);
		if (!ena)
			return GLYPH_BLANK;
		if (blank_zero && d == 4'd0)
			return GLYPH_BLANK;
		case (d)
			4'd0:       return GLYPH_0;
			4'd1:       return GLYPH_1;
			4'd2:       return GLYPH_2;
			4'd3:       return GLYPH_3;
			4'd4:       return GLYPH_4;
			4'd5:       return GLYPH_5;
			4'd6:       return GLYPH_6;
			4'd7:       return GLYPH_7;
			4'd8:       return GLYPH_8;
			4'd9:       return GLYPH_9;
			DIGIT_NONE: return GLYPH_MINUS;	// negative result
			default:    return GLYPH_ERR;	// a..e never expected
		endcase
	endfunction

	assign glyph[POS_A]    = encode(a_data, calc_ctrl.show_a, 1'b0);
	assign glyph[POS_B]    = encode(b_data, calc_ctrl.show_b, 1'b0);
	assign glyph[POS_TENS] = encode(split.tens, calc_ctrl.show_result, 1'b1);
	assign glyph[POS_ONES] = encode(split.ones, calc_ctrl.show_result, 1'b0);

	always_comb begin
		sel_glyph = GLYPH_BLANK;
		for (int i = 0; i < NUM_DIGITS; i++) begin
			if (gate[i])
				sel_glyph = glyph[i];
		end
	end

	// pattern and select leave together so the bank never ghosts
	always_ff @(posedge CLK or negedge RST_X) begin
		if (!RST_X) begin
			seg_out <= GLYPH_BLANK;
			seg_sel <= '1;	// all digits off
		end else begin
			seg_out <= sel_glyph;
			seg_sel <= ~gate;
		end
	end

endmodule

// File: verilog/calc_top.sv
module calc_top import calc_pkg::*, seg_pkg::*; #(
	parameter int SCAN_DIV = 4	// scan step length in clocks
) (
	input  logic      CLK,
	input  logic      RST_X,
	input  key_bank_t psw,	// keypad, active low
	output digit_t    a_data,
	output digit_t    b_data,
	output seg_t      seg_out,
	output gate_t     seg_sel
);

	key_evt_t   key_evt;
	calc_ctrl_t calc_ctrl;
	split_t     split;
	gate_t      gate;

	key_input key_input_i (
		.CLK     (CLK),
		.RST_X   (RST_X),
		.psw     (psw),
		.key_evt (key_evt)
	);

	calc_fsm calc_fsm_i (
		.CLK       (CLK),
		.RST_X     (RST_X),
		.key_evt   (key_evt),
		.calc_ctrl (calc_ctrl)
	);

	operand_result operand_result_i (
		.CLK       (CLK),
		.RST_X     (RST_X),
		.key_evt   (key_evt),
		.calc_ctrl (calc_ctrl),
		.a_data    (a_data),
		.b_data    (b_data),
		.split     (split)
	);

	scan_timer #(
		.SCAN_DIV (SCAN_DIV)
	) scan_timer_i (
		.CLK   (CLK),
		.RST_X (RST_X),
		.gate  (gate)
	);

	seg_display seg_display_i (
		.CLK       (CLK),
		.RST_X     (RST_X),
		.a_data    (a_data),
		.b_data    (b_data),
		.split     (split),
		.calc_ctrl (calc_ctrl),
		.gate      (gate),
		.seg_out   (seg_out),
		.seg_sel   (seg_sel)
	);

endmodule

// File: tests/calc_tb.sv
module calc_tb import calc_pkg::*, seg_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_LIMIT = 64;	// cycles, several full scans

	logic        CLK;
	logic        RST_X;
	key_bank_t   psw;	// active low keys
	digit_t      a_data;
	digit_t      b_data;
	seg_t        seg_out;
	gate_t       seg_sel;
	logic [31:0] rng;
	int          err_count;
	int          check_count;
	int          test_count;
	int          test_fail;

	calc_top #(.SCAN_DIV(4)) calc_top_i (
		.CLK(CLK), .RST_X(RST_X), .psw(psw),
		.a_data(a_data), .b_data(b_data), .seg_out(seg_out), .seg_sel(seg_sel)
	);

	initial begin
		CLK = 1'b0;
		forever #5 CLK = ~CLK;	// 100 MHz
	end

	function automatic logic [31:0] xorshift(logic [31:0] x);
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic int rand_below(int n);	// 0 .. n-1
		rng = xorshift(rng);
		return int'(rng % 32'(n));
	endfunction

	// segment pattern expected for a plain digit
	function automatic seg_t glyph_of(int d);
		case (d)
			0: return GLYPH_0;
			1: return GLYPH_1;
			2: return GLYPH_2;
			3: return GLYPH_3;
			4: return GLYPH_4;
			5: return GLYPH_5;
			6: return GLYPH_6;
			7: return GLYPH_7;
			8: return GLYPH_8;
			9: return GLYPH_9;
			default: return GLYPH_ERR;
		endcase
	endfunction

	task automatic check(input string name, input int got, input int exp);
		check_count++;
		if (got != exp) begin
			$display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
			err_count++;
		end
	endtask

	// hold 4 cycles, release, let the event settle
	task automatic press_key(input int k);
		@(posedge CLK);
		#1 psw[k] = 1'b0;
		repeat (4) @(posedge CLK);
		#1 psw[k] = 1'b1;
		repeat (4) @(posedge CLK);
	endtask

	task automatic read_digit(input digit_pos_t pos, output seg_t val);
		gate_t want;
		int    n;
		logic  found;
		want  = ~(gate_t'(1) << pos);	// select is active low
		found = 1'b0;
		n     = 0;
		val   = GLYPH_ERR;
		while (!found && n < WAIT_LIMIT) begin
			@(posedge CLK);
			#1;
			if (seg_sel == want) begin
				found = 1'b1;
				val   = seg_out;
			end
			n++;
		end
		if (!found) begin
			$display("timeout: display position %s never selected in %0d cycles",
				pos.name(), WAIT_LIMIT);
			err_count++;
		end
	endtask

	task automatic check_display(input seg_t ea, input seg_t eb, input seg_t et, input seg_t eo);
		seg_t got;
		read_digit(POS_A, got);
		check("seg_out at POS_A", int'(got), int'(ea));
		read_digit(POS_B, got);
		check("seg_out at POS_B", int'(got), int'(eb));
		read_digit(POS_TENS, got);
		check("seg_out at POS_TENS", int'(got), int'(et));
		read_digit(POS_ONES, got);
		check("seg_out at POS_ONES", int'(got), int'(eo));
	endtask

	task automatic report_test(input string name, input int err_start);
		test_count++;
		if (err_count == err_start) begin
			$display("test %s: passed", name);
		end else begin
			$display("test %s: failed, %0d errors", name, err_count - err_start);
			test_fail++;
		end
	endtask

	task automatic run_calc(input int a, input int op_key, input int b);
		press_key(a);
		press_key(op_key);
		press_key(b);
		press_key(KEY_EQUAL);
	endtask

	task automatic test_reset();
		int e0;
		e0 = err_count;
		check("a_data", int'(a_data), 0);
		check("b_data", int'(b_data), 0);
		check_display(GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK);
		report_test("reset", e0);
	endtask

	task automatic test_digit_entry();
		int e0;
		e0 = err_count;
		press_key(5);
		check("a_data", int'(a_data), 5);
		check_display(GLYPH_5, GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK);
		press_key(7);	// no operator yet, replaces a
		check("a_data", int'(a_data), 7);
		check_display(GLYPH_7, GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK);
		report_test("digit_entry", e0);
	endtask

	task automatic test_addition();
		int e0;
		int a;
		int b;
		int sum;
		e0 = err_count;
		for (int i = 0; i < 8; i++) begin
			a   = rand_below(10);
			b   = rand_below(10);
			sum = a + b;
			run_calc(a, KEY_ADD, b);
			check("a_data", int'(a_data), a);
			check("b_data", int'(b_data), b);
			// tens blank below 10, else a one
			check_display(glyph_of(a), glyph_of(b), (sum >= 10) ? GLYPH_1 : GLYPH_BLANK,
				glyph_of(sum % 10));
		end
		report_test("addition", e0);
	endtask

	task automatic test_subtraction();
		int e0;
		int a;
		int b;
		e0 = err_count;
		for (int i = 0; i < 8; i++) begin
			a = rand_below(9);
			b = a + 1 + rand_below(9 - a);	// strictly above a
			run_calc(a, KEY_SUB, b);
			check("b_data", int'(b_data), b);
			check_display(glyph_of(a), glyph_of(b), GLYPH_MINUS, glyph_of(b - a));
		end
		a = rand_below(10);
		run_calc(a, KEY_SUB, a);	// zero result
		check_display(glyph_of(a), glyph_of(a), GLYPH_BLANK, GLYPH_0);
		report_test("subtraction", e0);
	endtask

	task automatic test_clear();
		int e0;
		e0 = err_count;
		press_key(3);
		press_key(KEY_ADD);
		press_key(KEY_CLEAR);	// mid entry
		check_display(GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK);
		press_key(4);
		check("a_data", int'(a_data), 4);
		check_display(GLYPH_4, GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK);
		run_calc(4, KEY_ADD, 2);
		press_key(KEY_CLEAR);	// after a result
		check_display(GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK);
		press_key(6);
		check("a_data", int'(a_data), 6);
		check_display(GLYPH_6, GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK);
		report_test("clear", e0);
	endtask

	task automatic test_new_from_result();
		int e0;
		e0 = err_count;
		run_calc(3, KEY_SUB, 8);
		check_display(GLYPH_3, GLYPH_8, GLYPH_MINUS, GLYPH_5);
		press_key(2);
		check("a_data", int'(a_data), 2);
		check("b_data", int'(b_data), 8);	// kept, only hidden
		check_display(GLYPH_2, GLYPH_BLANK, GLYPH_BLANK, GLYPH_BLANK);
		report_test("new_from_result", e0);
	endtask

	initial begin
		psw         = '1;	// nothing pressed
		RST_X       = 1'b0;
		rng         = 32'hd48e;
		err_count   = 0;
		check_count = 0;
		test_count  = 0;
		test_fail   = 0;
		repeat (5) @(posedge CLK);
		#1 RST_X = 1'b1;
		test_reset();
		test_digit_entry();
		test_addition();
		test_subtraction();
		test_clear();
		test_new_from_result();
		$display("tests %0d, tests failed %0d, checks %0d, errors %0d",
			test_count, test_fail, check_count, err_count);
		if (err_count == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: src.f
verilog/calc_pkg.sv
verilog/seg_pkg.sv
verilog/key_input.sv
verilog/calc_fsm.sv
verilog/operand_result.sv
verilog/scan_timer.sv
verilog/seg_display.sv
verilog/calc_top.sv
tests/calc_tb.sv

// File: run.sh
#!/bin/sh
# build and run the calculator testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module calc_tb -Mdir obj_dir -o calc_sim \
	&& ./obj_dir/calc_sim > sim.log 2>&1 \
	|| echo "build or simulation did not complete"
grep -q "TEST PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
